// ==== bit_packer.sv ====
`timescale 1ns/1ps

module bit_packer (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  clear,
   input  logic                  osc_bit,
   output logic                  word_valid,
   output nco_pkg::sample_word_t word
);
   import nco_pkg::*;

   localparam int CNT_W = $clog2(WORD_BITS);
   localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(WORD_BITS - 1);

   logic [CNT_W-1:0] bit_cnt;
   sample_word_t     shift_reg;

   // bits enter at the lsb, so the oldest bit ends up in the msb
   always_ff @(posedge clk) begin
      shift_reg <= {shift_reg[WORD_BITS-2:0], osc_bit};
   end

   // word is complete on the cycle after the sixteenth shift
   assign word = shift_reg;

   always_ff @(posedge clk) begin
      if (reset || clear) begin
         bit_cnt    <= '0;
         word_valid <= 1'b0;
      end else begin
         // counter wraps to zero after the last bit
         bit_cnt    <= bit_cnt + 1'b1;
         word_valid <= (bit_cnt == LAST_BIT);
      end
   end

endmodule

// ==== cmd_decoder.sv ====
`timescale 1ns/1ps

module cmd_decoder (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      rx_valid,
   input  spi_cmd_pkg::spi_frame_t   rx_frame,
   output logic                      clear,
   output logic                      load,
   output logic                      pop,
   output nco_pkg::phase_t           control_word,
   input  nco_pkg::sample_word_t     rd_word,
   input  nco_pkg::capture_status_t  status,
   output spi_cmd_pkg::spi_frame_t   tx_frame
);
   import nco_pkg::*;
   import spi_cmd_pkg::*;

   typedef enum logic {
      ST_CMD,
      ST_FREQ
   } state_t;

   state_t     state;
   cmd_frame_t cmd;
   opcode_t    last_op;
   logic       reply_req;
   logic       reply_load;

   assign cmd = cmd_frame_t'(rx_frame);

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= ST_CMD;
         clear   <= 1'b0;
         load    <= 1'b0;
         pop     <= 1'b0;
         last_op <= OP_NOP;
      end else begin
         clear <= 1'b0;
         load  <= 1'b0;
         pop   <= 1'b0;
         if (rx_valid) begin
            if (state == ST_FREQ) begin
               // data frame carries the whole control word, reply is zero
               load    <= 1'b1;
               last_op <= OP_NOP;
               state   <= ST_CMD;
            end else begin
               case (cmd.opcode)
                  OP_INIT: begin
                     clear   <= 1'b1;
                     last_op <= OP_INIT;
                  end
                  OP_SET_FREQ: begin
                     last_op <= OP_SET_FREQ;
                     state   <= ST_FREQ;
                  end
                  OP_READ_SAMPLE: begin
                     pop     <= 1'b1;
                     last_op <= OP_READ_SAMPLE;
                  end
                  OP_READ_STATUS: last_op <= OP_READ_STATUS;
                  // unknown opcodes act as nop
                  default: last_op <= OP_NOP;
               endcase
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_valid && state == ST_FREQ) begin
         control_word <= phase_t'(rx_frame);
      end
   end

   // wait one cycle for the buffer read, then build the reply
   always_ff @(posedge clk) begin
      if (reset) begin
         reply_req  <= 1'b0;
         reply_load <= 1'b0;
         tx_frame   <= '0;
      end else begin
         reply_req  <= rx_valid;
         reply_load <= reply_req;
         if (reply_load) begin
            case (last_op)
               OP_READ_SAMPLE: tx_frame <= spi_frame_t'(rd_word);
               OP_READ_STATUS: tx_frame <= spi_frame_t'(status);
               default:        tx_frame <= '0;
            endcase
         end
      end
   end

endmodule

// ==== nco.sv ====
`timescale 1ns/1ps

module nco (
   input  logic            clk,
   input  logic            reset,
   input  logic            clear,
   input  nco_pkg::phase_t control_word,
   input  logic            load,
   output logic            osc_bit
);
   import nco_pkg::*;

   phase_t freq_word;
   phase_t phase;
   phase_t phase_next;

   assign phase_next = phase + freq_word;

   // square wave from the msb of the advanced phase
   assign osc_bit = phase_next[PHASE_BITS-1];

   always_ff @(posedge clk) begin
      if (reset) begin
         freq_word <= '0;
      end else if (load) begin
         freq_word <= control_word;
      end
   end

   always_ff @(posedge clk) begin
      if (reset || clear) begin
         phase <= '0;
      end else begin
         phase <= phase_next;
      end
   end

endmodule

// ==== nco_capture_tb.sv ====
`timescale 1ns/1ps

module nco_capture_tb;
   import nco_pkg::*;
   import spi_cmd_pkg::*;

   // deep enough that one capture outlasts a single spi frame
   localparam int          BUFFER_DEPTH = 12;
   localparam int          HALF_SCK     = 4;
   localparam int          FRAME_GAP    = 10;
   localparam int          POLL_LIMIT   = 200;
   localparam int          RESET_LIMIT  = 100;
   localparam int          ROUNDS       = 6;
   localparam logic [31:0] SEED         = 32'h49854ba2;

   logic        clk;
   logic        reset;
   logic        sck;
   logic        ss_n;
   logic        mosi;
   logic        miso;

   logic [31:0] rng;
   logic        reply_pending;
   phase_t      model_cw;

   tb_clock_gen #(
      .HALF_PERIOD  (4),
      .RESET_CYCLES (8)
   ) u_clock_gen (
      .clk   (clk),
      .reset (reset)
   );

   nco_capture_top #(
      .BUFFER_DEPTH (BUFFER_DEPTH)
   ) u_dut (
      .clk   (clk),
      .reset (reset),
      .sck   (sck),
      .ss_n  (ss_n),
      .mosi  (mosi),
      .miso  (miso)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic next_rand(output logic [31:0] r);
      rng = xorshift32(rng);
      r = rng;
   endtask

   // bit j of word k is the msb of phase (16k + j + 1) * c
   function automatic sample_word_t model_word(input phase_t c, input int k);
      sample_word_t w;
      logic [31:0]  prod;
      for (int j = 0; j < WORD_BITS; j++) begin
         prod = 32'(WORD_BITS * k + j + 1) * 32'(c);
         w[WORD_BITS - 1 - j] = prod[PHASE_BITS - 1];
      end
      return w;
   endfunction

   function automatic capture_status_t expected_status(input logic done, input int count);
      capture_status_t s;
      s.done     = done;
      s.reserved = '0;
      s.count    = COUNT_BITS'(count);
      return s;
   endfunction

   task automatic check_word(input sample_word_t got, input sample_word_t exp,
                             input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp);
         $display("Test failed");
         $fatal(1, "sample word mismatch");
      end
   endtask

   task automatic check_status(input capture_status_t got, input capture_status_t exp,
                               input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s, got done=%b count=%0d reserved=%h, %0s",
                  $time, what, got.done, got.count, got.reserved,
                  $sformatf("expected done=%b count=%0d", exp.done, exp.count));
         $display("Test failed");
         $fatal(1, "status word mismatch");
      end
   endtask

   // one mode 0 frame, msb first; miso is sampled late in the sck high phase
   task automatic exchange(input spi_frame_t tx, input logic replies, output spi_frame_t rx);
      @(posedge clk);
      ss_n <= 1'b0;
      mosi <= tx[FRAME_BITS-1];
      for (int i = FRAME_BITS - 1; i >= 0; i--) begin
         repeat (HALF_SCK) @(posedge clk);
         sck <= 1'b1;
         repeat (HALF_SCK - 1) @(posedge clk);
         @(negedge clk);
         rx[i] = miso;
         @(posedge clk);
         sck <= 1'b0;
         if (i > 0) begin
            mosi <= tx[i-1];
         end
      end
      repeat (HALF_SCK) @(posedge clk);
      ss_n <= 1'b1;
      mosi <= 1'b0;
      repeat (FRAME_GAP - 1) @(posedge clk);
      // a frame that asks for no data leaves a zero reply behind
      if (!reply_pending) begin
         check_word(sample_word_t'(rx), '0, "reply to a frame without data");
      end
      reply_pending = replies;
   endtask

   task automatic send_command(input opcode_t op, input logic replies);
      cmd_frame_t  cmd;
      spi_frame_t  rx;
      logic [31:0] r;
      next_rand(r);
      cmd.opcode = op;
      cmd.arg    = r[7:0];
      exchange(spi_frame_t'(cmd), replies, rx);
   endtask

   task automatic fetch_reply(output spi_frame_t rx);
      cmd_frame_t cmd;
      cmd.opcode = OP_NOP;
      cmd.arg    = 8'h00;
      exchange(spi_frame_t'(cmd), 1'b0, rx);
   endtask

   task automatic read_status(output capture_status_t s);
      spi_frame_t rx;
      send_command(OP_READ_STATUS, 1'b1);
      fetch_reply(rx);
      s = capture_status_t'(rx);
   endtask

   task automatic read_sample(output sample_word_t w);
      spi_frame_t rx;
      send_command(OP_READ_SAMPLE, 1'b1);
      fetch_reply(rx);
      w = sample_word_t'(rx);
   endtask

   task automatic set_freq(input phase_t c);
      spi_frame_t rx;
      send_command(OP_SET_FREQ, 1'b0);
      exchange(spi_frame_t'(c), 1'b0, rx);
      model_cw = c;
   endtask

   task automatic start_capture();
      send_command(OP_INIT, 1'b0);
   endtask

   // roughly one call in four sends a nop
   task automatic maybe_nop();
      logic [31:0] r;
      next_rand(r);
      if (r[1:0] == 2'b00) begin
         send_command(OP_NOP, 1'b0);
      end
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (reset !== 1'b0 && cycles < RESET_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      if (reset !== 1'b0) begin
         $display("reset was never released");
         $display("Test failed");
         $fatal(1, "reset timeout");
      end
      repeat (2) @(posedge clk);
   endtask

   task automatic wait_capture_done(output capture_status_t s);
      int polls;
      polls = 0;
      s = '0;
      while (!s.done && polls < POLL_LIMIT) begin
         read_status(s);
         polls++;
      end
      if (!s.done) begin
         $display("capture never completed within %0d status reads", POLL_LIMIT);
         $display("Test failed");
         $fatal(1, "status poll limit reached");
      end
   endtask

   // words come back in write order, count drops by one per read
   task automatic drain_and_check();
      sample_word_t    w;
      capture_status_t s;
      for (int k = 0; k < BUFFER_DEPTH; k++) begin
         read_sample(w);
         check_word(w, model_word(model_cw, k), $sformatf("captured word %0d", k));
         read_status(s);
         check_status(s, expected_status(1'b1, BUFFER_DEPTH - k - 1),
                      $sformatf("status after read %0d", k));
         maybe_nop();
      end
   endtask

   task automatic read_past_empty();
      logic [31:0]     r;
      sample_word_t    w;
      capture_status_t s;
      next_rand(r);
      for (int i = 0; i <= int'(r[1:0]); i++) begin
         read_sample(w);
         check_word(w, '0, "read from empty buffer");
         maybe_nop();
      end
      read_status(s);
      check_status(s, expected_status(1'b1, 0), "status of empty buffer");
   endtask

   initial begin
      logic [31:0]     r;
      capture_status_t s;
      sample_word_t    w;

      sck           = 1'b0;
      ss_n          = 1'b1;
      mosi          = 1'b0;
      rng           = SEED;
      reply_pending = 1'b0;
      model_cw      = '0;

      wait_reset_release();

      // idle buffer straight out of reset
      read_status(s);
      check_status(s, expected_status(1'b1, 0), "status after reset");
      read_sample(w);
      check_word(w, '0, "sample read after reset");
      maybe_nop();

      for (int round = 0; round < ROUNDS; round++) begin
         next_rand(r);
         set_freq(r[15:0]);
         start_capture();
         if (round == 0 || r[16]) begin
            // second init lands while the first capture is still running
            start_capture();
         end
         if (r[17]) begin
            // new word, then restart from phase zero
            maybe_nop();
            next_rand(r);
            set_freq(r[15:0]);
            start_capture();
         end
         maybe_nop();
         wait_capture_done(s);
         check_status(s, expected_status(1'b1, BUFFER_DEPTH),
                      $sformatf("status at end of capture %0d", round));
         drain_and_check();
         read_past_empty();
      end

      $display("Test passed");
      $finish;
   end

endmodule

// ==== nco_capture_top.f ====
nco_pkg.sv
spi_cmd_pkg.sv
nco.sv
bit_packer.sv
sample_buffer.sv
spi_slave.sv
cmd_decoder.sv
nco_capture_top.sv
tb_clock_gen.sv
nco_capture_tb.sv

// ==== nco_capture_top.sv ====
`timescale 1ns/1ps

module nco_capture_top #(
   parameter int BUFFER_DEPTH = 8
) (
   input  logic clk,
   input  logic reset,
   input  logic sck,
   input  logic ss_n,
   input  logic mosi,
   output logic miso
);
   import nco_pkg::*;
   import spi_cmd_pkg::*;

   // host link
   logic            rx_valid;
   spi_frame_t      rx_frame;
   spi_frame_t      tx_frame;

   // capture control
   logic            clear;
   logic            load;
   logic            pop;
   phase_t          control_word;

   // capture data path
   logic            osc_bit;
   logic            word_valid;
   sample_word_t    word;
   sample_word_t    rd_word;
   capture_status_t status;

   nco u_nco (
      .clk          (clk),
      .reset        (reset),
      .clear        (clear),
      .control_word (control_word),
      .load         (load),
      .osc_bit      (osc_bit)
   );

   bit_packer u_bit_packer (
      .clk        (clk),
      .reset      (reset),
      .clear      (clear),
      .osc_bit    (osc_bit),
      .word_valid (word_valid),
      .word       (word)
   );

   sample_buffer #(
      .BUFFER_DEPTH (BUFFER_DEPTH)
   ) u_sample_buffer (
      .clk        (clk),
      .reset      (reset),
      .clear      (clear),
      .word_valid (word_valid),
      .word       (word),
      .pop        (pop),
      .rd_word    (rd_word),
      .status     (status)
   );

   spi_slave u_spi_slave (
      .clk      (clk),
      .reset    (reset),
      .sck      (sck),
      .ss_n     (ss_n),
      .mosi     (mosi),
      .miso     (miso),
      .rx_valid (rx_valid),
      .rx_frame (rx_frame),
      .tx_frame (tx_frame)
   );

   cmd_decoder u_cmd_decoder (
      .clk          (clk),
      .reset        (reset),
      .rx_valid     (rx_valid),
      .rx_frame     (rx_frame),
      .clear        (clear),
      .load         (load),
      .pop          (pop),
      .control_word (control_word),
      .rd_word      (rd_word),
      .status       (status),
      .tx_frame     (tx_frame)
   );

endmodule

// ==== nco_pkg.sv ====
package nco_pkg;

   // oscillator phase and frequency word width
   localparam int PHASE_BITS = 16;

   // oscillator bits per captured word
   localparam int WORD_BITS = 16;

   // width of the unread word count in the status word
   localparam int COUNT_BITS = 4;

   typedef logic [PHASE_BITS-1:0] phase_t;

   // first bit packed lands in the msb
   typedef logic [WORD_BITS-1:0] sample_word_t;

   // status word returned to the host
   typedef struct packed {
      logic                  done;
      logic [10:0]           reserved;
      logic [COUNT_BITS-1:0] count;
   } capture_status_t;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the nco capture testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module nco_capture_tb \
   -f nco_capture_top.f \
   --Mdir obj_dir -o nco_capture_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator compile failed with status $status"
   exit "$status"
fi

./obj_dir/nco_capture_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation failed with status $status"
   exit "$status"
fi

echo "simulation finished with status 0"
exit 0

// ==== sample_buffer.sv ====
`timescale 1ns/1ps

module sample_buffer #(
   parameter int BUFFER_DEPTH = 8
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     clear,
   input  logic                     word_valid,
   input  nco_pkg::sample_word_t    word,
   input  logic                     pop,
   output nco_pkg::sample_word_t    rd_word,
   output nco_pkg::capture_status_t status
);
   import nco_pkg::*;

   localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(BUFFER_DEPTH - 1);
   localparam logic [COUNT_BITS-1:0] FULL_COUNT = COUNT_BITS'(BUFFER_DEPTH);

   // count has to fit the status field
   if (BUFFER_DEPTH > 15 || BUFFER_DEPTH < 1) begin : g_depth_check
      $error("sample_buffer: BUFFER_DEPTH must be between 1 and 15");
   end

   sample_word_t          mem [BUFFER_DEPTH];
   logic [PTR_W-1:0]      wr_ptr;
   logic [PTR_W-1:0]      rd_ptr;
   logic [COUNT_BITS-1:0] count;
   logic [COUNT_BITS-1:0] written;
   logic                  done;
   logic                  wr_en;
   logic                  rd_en;

   // one shot, stops once a full buffer has been taken since clear
   assign done  = (written == FULL_COUNT);
   assign wr_en = word_valid && !done && !clear;
   assign rd_en = pop && (count != '0) && !clear;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= word;
      end
   end

   // empty reads give zero
   always_ff @(posedge clk) begin
      if (pop) begin
         rd_word <= (count != '0) ? mem[rd_ptr] : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         written <= FULL_COUNT;
      end else if (clear) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         written <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr  <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            written <= written + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + (wr_en ? 1'b1 : 1'b0) - (rd_en ? 1'b1 : 1'b0);
      end
   end

   assign status.done     = done;
   assign status.reserved = '0;
   assign status.count    = count;

   // write pointer tracks the words taken since clear
   assert property (@(posedge clk) disable iff (reset)
      written <= FULL_COUNT && int'(wr_ptr) == int'(written) % BUFFER_DEPTH)
      else $error("sample_buffer: write accepted after capture was done");

   // read pointer trails the words taken by the unread count
   assert property (@(posedge clk) disable iff (reset)
      int'(rd_ptr) == (int'(written) - int'(count)) % BUFFER_DEPTH)
      else $error("sample_buffer: pop underflowed the read pointer");

endmodule

// ==== spi_cmd_pkg.sv ====
package spi_cmd_pkg;

   // bits per spi frame, msb first on the wire
   localparam int FRAME_BITS = 16;

   typedef logic [FRAME_BITS-1:0] spi_frame_t;

   // host opcodes, carried in the upper byte of a command frame
   typedef enum logic [7:0] {
      OP_NOP          = 8'h00,
      OP_INIT         = 8'h01,
      OP_SET_FREQ     = 8'h02,
      OP_READ_SAMPLE  = 8'h03,
      OP_READ_STATUS  = 8'h04
   } opcode_t;

   // command frame layout, arg is unused by every opcode
   typedef struct packed {
      opcode_t    opcode;
      logic [7:0] arg;
   } cmd_frame_t;

endpackage

// ==== spi_slave.sv ====
`timescale 1ns/1ps

module spi_slave (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   sck,
   input  logic                   ss_n,
   input  logic                   mosi,
   output logic                   miso,
   output logic                   rx_valid,
   output spi_cmd_pkg::spi_frame_t rx_frame,
   input  spi_cmd_pkg::spi_frame_t tx_frame
);
   import spi_cmd_pkg::*;

   localparam int CNT_W = $clog2(FRAME_BITS);
   localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(FRAME_BITS - 1);

   logic [1:0]       sck_sync;
   logic [1:0]       ss_sync;
   logic [1:0]       mosi_sync;
   logic             sck_prev;
   logic             ss_prev;
   logic             sck_rise;
   logic             sck_fall;
   logic             ss_fall;
   logic             selected;
   logic [CNT_W-1:0] bit_cnt;
   spi_frame_t       rx_shift;
   spi_frame_t       tx_shift;

   // two flop synchronizers, idle levels for mode 0 with slave deselected
   always_ff @(posedge clk) begin
      if (reset) begin
         sck_sync <= 2'b00;
         ss_sync  <= 2'b11;
         sck_prev <= 1'b0;
         ss_prev  <= 1'b1;
      end else begin
         sck_sync <= {sck_sync[0], sck};
         ss_sync  <= {ss_sync[0], ss_n};
         sck_prev <= sck_sync[1];
         ss_prev  <= ss_sync[1];
      end
   end

   // mosi takes the same delay as sck so the sampled bit lines up
   always_ff @(posedge clk) begin
      mosi_sync <= {mosi_sync[0], mosi};
   end

   assign sck_rise = sck_sync[1] && !sck_prev;
   assign sck_fall = !sck_sync[1] && sck_prev;
   assign ss_fall  = ss_prev && !ss_sync[1];
   assign selected = !ss_sync[1];

   always_ff @(posedge clk) begin
      if (reset) begin
         bit_cnt  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         if (!selected) begin
            bit_cnt <= '0;
         end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == LAST_BIT) begin
               rx_valid <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (selected && sck_rise) begin
         rx_shift <= {rx_shift[FRAME_BITS-2:0], mosi_sync[1]};
         if (bit_cnt == LAST_BIT) begin
            rx_frame <= {rx_shift[FRAME_BITS-2:0], mosi_sync[1]};
         end
      end
   end

   // reply is captured at frame start, then moves out on falling edges
   always_ff @(posedge clk) begin
      if (reset) begin
         tx_shift <= '0;
      end else if (ss_fall) begin
         tx_shift <= tx_frame;
      end else if (selected && sck_fall) begin
         tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};
      end
   end

   assign miso = tx_shift[FRAME_BITS-1];

   // host holds ss_n low past the last sck edge of a frame
   assert property (@(posedge clk) disable iff (reset)
      rx_valid |-> selected)
      else $error("spi_slave: frame completed while ss_n was high");

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int HALF_PERIOD  = 4,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   // reset held from time zero, released on a rising edge
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
   end

endmodule
